/* build.f */
+incdir+.
cl_fsb_pkg.sv
cl_rst_flr.sv
cl_ocl_slave.sv
cl_id_regs.sv
cl_loopback_fifo.sv
cl_fsb.sv
tb_clk_gen.sv
tb_cl_fsb.sv

/* run.sh */
#!/bin/sh
# compile the cl_fsb testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cl_fsb -f build.f \
  -o sim_tb_cl_fsb || exit 1

out="$(./obj_dir/sim_tb_cl_fsb)"
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "test passed" && exit 0 || exit 1

/* tb_cl_fsb.sv */
// directed testbench for the cl_fsb shell top, runs ocl register and flr tests and reports
`timescale 1ns/10ps
`include "cl_fsb_defs.svh"

module tb_cl_fsb;

  import cl_fsb_pkg::*;

  // watchdog budget is 200 transactions of at most 30 cycles, plus reset and flr margin
  localparam int CLK_PERIOD_NS = 8;
  localparam int MAX_TXNS      = 200;
  localparam int TXN_CYCLES    = 30;
  localparam int WATCHDOG_NS   = (MAX_TXNS * TXN_CYCLES + 1500) * CLK_PERIOD_NS;
  localparam int SHORT_STALL   = 3;
  localparam int LONG_STALL    = 15;

  logic        clk_main_a0;
  logic        sync_rst_n;
  logic        flr_assert;
  logic        flr_done;
  logic        awvalid;
  ocl_addr_t   awaddr;
  logic        awready;
  logic        wvalid;
  ocl_data_t   wdata;
  ocl_strb_t   wstrb;
  logic        wready;
  logic        bvalid;
  ocl_resp_t   bresp;
  logic        bready;
  logic        arvalid;
  ocl_addr_t   araddr;
  logic        arready;
  logic        rvalid;
  ocl_data_t   rdata;
  ocl_resp_t   rresp;
  logic        rready;
  int          errors = 0;
  logic [31:0] lcg_state = 32'h853f;
  ocl_data_t   scratch_exp;
  ocl_data_t   lb_exp [$];

  tb_clk_gen u_clk_gen (
    .clk_o   (clk_main_a0),
    .rst_n_o (sync_rst_n)
  );

  cl_fsb DUT (
    .clk_main_a0   (clk_main_a0),
    .sync_rst_n    (sync_rst_n),
    .flr_assert_i  (flr_assert),
    .flr_done_o    (flr_done),
    .ocl_awvalid_i (awvalid),
    .ocl_awaddr_i  (awaddr),
    .ocl_awready_o (awready),
    .ocl_wvalid_i  (wvalid),
    .ocl_wdata_i   (wdata),
    .ocl_wstrb_i   (wstrb),
    .ocl_wready_o  (wready),
    .ocl_bvalid_o  (bvalid),
    .ocl_bresp_o   (bresp),
    .ocl_bready_i  (bready),
    .ocl_arvalid_i (arvalid),
    .ocl_araddr_i  (araddr),
    .ocl_arready_o (arready),
    .ocl_rvalid_o  (rvalid),
    .ocl_rdata_o   (rdata),
    .ocl_rresp_o   (rresp),
    .ocl_rready_i  (rready)
  );

  // --------------------
  // helpers
  // --------------------
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
    assert (act_val === exp_val)
    else
    begin
      $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
      errors++;
    end
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond)
    else
    begin
      $display("Error at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  // one write, a harmless read is held pending while bready stays low
  task automatic axil_write(input ocl_addr_t addr, input ocl_data_t data,
                            input ocl_strb_t strb, input int max_stall,
                            output ocl_resp_t resp);
    int stall;
    stall = int'(next_random() >> 16) % (max_stall + 1);
    @(negedge clk_main_a0);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    #1;
    while (!awready)
    begin
      @(negedge clk_main_a0);
      #1;
    end
    require(wready, "wready was not raised together with awready");
    @(negedge clk_main_a0);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    araddr  = '0;
    arvalid = (stall > 0);
    bready  = (stall == 0);
    #1;
    require(bvalid, "no write response one cycle after the accept");
    resp = bresp;
    for (int k = stall; k > 0; k--)
    begin
      require(!arready, "read accepted while a write response was pending");
      require(bvalid, "write response dropped before bready");
      compare("bresp", 32'(resp), 32'(bresp));
      @(negedge clk_main_a0);
      arvalid = (k > 1);
      bready  = (k == 1);
      #1;
    end
    @(negedge clk_main_a0);
    bready = 1'b0;
  endtask

  // one read, a write to the constant id word is held pending while rready stays low
  task automatic axil_read(input ocl_addr_t addr, input int max_stall,
                           output ocl_data_t data, output ocl_resp_t resp);
    int stall;
    stall = int'(next_random() >> 16) % (max_stall + 1);
    @(negedge clk_main_a0);
    arvalid = 1'b1;
    araddr  = addr;
    #1;
    while (!arready)
    begin
      @(negedge clk_main_a0);
      #1;
    end
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    awaddr  = '0;
    wstrb   = '0;
    awvalid = (stall > 0);
    wvalid  = (stall > 0);
    rready  = (stall == 0);
    #1;
    require(rvalid, "no read data one cycle after the accept");
    data = rdata;
    resp = rresp;
    for (int k = stall; k > 0; k--)
    begin
      require(!awready, "write accepted while read data was pending");
      require(rvalid, "read data dropped before rready");
      compare("rdata", data, rdata);
      compare("rresp", 32'(resp), 32'(rresp));
      @(negedge clk_main_a0);
      awvalid = (k > 1);
      wvalid  = (k > 1);
      rready  = (k == 1);
      #1;
    end
    @(negedge clk_main_a0);
    rready = 1'b0;
  endtask

  task automatic write_check(input ocl_addr_t addr, input ocl_data_t data,
                             input ocl_strb_t strb, input ocl_resp_t exp_resp,
                             input int max_stall);
    ocl_resp_t resp;
    axil_write(addr, data, strb, max_stall, resp);
    compare($sformatf("bresp @%h", addr), 32'(exp_resp), 32'(resp));
  endtask

  task automatic read_check(input ocl_addr_t addr, input ocl_data_t exp_data,
                            input ocl_resp_t exp_resp, input int max_stall);
    ocl_data_t data;
    ocl_resp_t resp;
    axil_read(addr, max_stall, data, resp);
    compare($sformatf("rdata @%h", addr), exp_data, data);
    compare($sformatf("rresp @%h", addr), 32'(exp_resp), 32'(resp));
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic reset_release();
    repeat (2) @(negedge clk_main_a0);
    #1;
    while (!sync_rst_n)
    begin
      require(!bvalid && !rvalid && !flr_done, "response or flr done high during reset");
      @(negedge clk_main_a0);
      #1;
    end
    repeat (`CL_RST_PIPE_STAGES)
    begin
      require(!bvalid && !rvalid && !flr_done, "response or flr done high in the reset pipe");
      @(negedge clk_main_a0);
      #1;
    end
    scratch_exp = next_random();
    write_check(32'h0000_0008, scratch_exp, 4'hF, `CL_RESP_OKAY, SHORT_STALL);
  endtask

  task automatic id_window();
    ocl_data_t data;
    ocl_strb_t strb;
    read_check(32'h0000_0000, `CL_SH_ID0, `CL_RESP_OKAY, SHORT_STALL);
    read_check(32'h0000_0004, `CL_SH_ID1, `CL_RESP_OKAY, SHORT_STALL);
    write_check(32'h0000_0000, next_random(), 4'hF, `CL_RESP_OKAY, SHORT_STALL);
    write_check(32'h0000_0004, next_random(), 4'hF, `CL_RESP_OKAY, SHORT_STALL);
    read_check(32'h0000_0000, `CL_SH_ID0, `CL_RESP_OKAY, SHORT_STALL);
    read_check(32'h0000_0004, `CL_SH_ID1, `CL_RESP_OKAY, SHORT_STALL);
    read_check(32'h0000_000C, 32'h0, `CL_RESP_OKAY, SHORT_STALL);
    // bytes with a clear strobe keep their old value
    repeat (4)
    begin
      data = next_random();
      strb = ocl_strb_t'(next_random() >> 20);
      write_check(32'h0000_0008, data, strb, `CL_RESP_OKAY, SHORT_STALL);
      for (int b = 0; b < 4; b++)
      begin
        if (strb[b])
          scratch_exp[8*b +: 8] = data[8*b +: 8];
      end
      read_check(32'h0000_0008, scratch_exp, `CL_RESP_OKAY, SHORT_STALL);
    end
  endtask

  task automatic loopback_order();
    ocl_data_t word;
    for (int n = 1; n <= `CL_LB_DEPTH; n++)
    begin
      repeat (n)
      begin
        word = next_random();
        lb_exp.push_back(word);
        write_check(32'h0000_1000, word, 4'hF, `CL_RESP_OKAY, SHORT_STALL);
      end
      read_check(32'h0000_1004, 32'(n), `CL_RESP_OKAY, SHORT_STALL);
      while (lb_exp.size() > 0)
        read_check(32'h0000_1000, lb_exp.pop_front(), `CL_RESP_OKAY, SHORT_STALL);
      read_check(32'h0000_1004, 32'h0, `CL_RESP_OKAY, SHORT_STALL);
    end
  endtask

  task automatic error_responses();
    ocl_data_t word;
    read_check(32'h0000_1000, 32'h0, `CL_RESP_SLVERR, SHORT_STALL);
    repeat (`CL_LB_DEPTH)
    begin
      word = next_random();
      lb_exp.push_back(word);
      write_check(32'h0000_1000, word, 4'hF, `CL_RESP_OKAY, SHORT_STALL);
    end
    // ninth push is refused and stores nothing
    write_check(32'h0000_1000, next_random(), 4'hF, `CL_RESP_SLVERR, SHORT_STALL);
    read_check(32'h0000_1004, 32'(`CL_LB_DEPTH), `CL_RESP_OKAY, SHORT_STALL);
    while (lb_exp.size() > 0)
      read_check(32'h0000_1000, lb_exp.pop_front(), `CL_RESP_OKAY, SHORT_STALL);
    write_check(32'h0000_2000, next_random(), 4'hF, `CL_RESP_SLVERR, SHORT_STALL);
    read_check(32'h0000_2000, 32'h0, `CL_RESP_SLVERR, SHORT_STALL);
    write_check(32'h0000_3000, next_random(), 4'hF, `CL_RESP_SLVERR, SHORT_STALL);
    read_check(32'h0000_3000, 32'h0, `CL_RESP_SLVERR, SHORT_STALL);
  endtask

  task automatic back_pressure();
    repeat (6)
    begin
      scratch_exp = next_random();
      write_check(32'h0000_0008, scratch_exp, 4'hF, `CL_RESP_OKAY, LONG_STALL);
      read_check(32'h0000_0008, scratch_exp, `CL_RESP_OKAY, LONG_STALL);
    end
  endtask

  task automatic flr_handshake();
    @(negedge clk_main_a0);
    flr_assert = 1'b1;
    // done rises two cycles after the assert, then alternates
    for (int k = 1; k <= 6; k++)
    begin
      @(negedge clk_main_a0);
      #1;
      compare("flr_done_o", 32'(k % 2 == 0), 32'(flr_done));
    end
    @(negedge clk_main_a0);
    flr_assert = 1'b0;
    for (int k = 1; k <= 4; k++)
    begin
      @(negedge clk_main_a0);
      #1;
      if (k >= 2)
        compare("flr_done_o", 32'h0, 32'(flr_done));
    end
  endtask

  // --------------------
  // run and watchdog
  // --------------------
  initial
  begin
    flr_assert  = 1'b0;
    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = '0;
    rready      = 1'b0;
    scratch_exp = '0;
    reset_release();
    id_window();
    loopback_order();
    error_responses();
    back_pressure();
    flr_handshake();
    $display("summary: %0d errors", errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("summary: %0d errors", errors);
    $display("test failed");
    $finish;
  end

endmodule

/* tb_clk_gen.sv */
// clock and power-on reset source for the cl_fsb testbench, instantiated by the testbench top
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD_NS = 4;
  localparam int RESET_CYCLES   = 10;

  initial
  begin
    clk_o = 1'b0;
    forever
      #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // release on a falling edge, clear of the sampling edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* cl_fsb.sv */
// custom-logic shell top, ocl register access with reset staging and flr acknowledge
`timescale 1ns/10ps

module cl_fsb (
  input  logic                  clk_main_a0,
  input  logic                  sync_rst_n,
  input  logic                  flr_assert_i,
  output logic                  flr_done_o,
  input  logic                  ocl_awvalid_i,
  input  cl_fsb_pkg::ocl_addr_t ocl_awaddr_i,
  output logic                  ocl_awready_o,
  input  logic                  ocl_wvalid_i,
  input  cl_fsb_pkg::ocl_data_t ocl_wdata_i,
  input  cl_fsb_pkg::ocl_strb_t ocl_wstrb_i,
  output logic                  ocl_wready_o,
  output logic                  ocl_bvalid_o,
  output cl_fsb_pkg::ocl_resp_t ocl_bresp_o,
  input  logic                  ocl_bready_i,
  input  logic                  ocl_arvalid_i,
  input  cl_fsb_pkg::ocl_addr_t ocl_araddr_i,
  output logic                  ocl_arready_o,
  output logic                  ocl_rvalid_o,
  output cl_fsb_pkg::ocl_data_t ocl_rdata_o,
  output cl_fsb_pkg::ocl_resp_t ocl_rresp_o,
  input  logic                  ocl_rready_i
);

  import cl_fsb_pkg::*;

  logic      blk_rst_n;
  reg_idx_t  reg_idx;
  ocl_data_t reg_wdata;
  ocl_strb_t reg_wstrb;
  logic      id_wr;
  logic      id_rd;
  logic      lb_wr;
  logic      lb_rd;
  ocl_data_t id_rdata;
  ocl_data_t lb_rdata;
  logic      lb_err;

  // --------------------
  // reset and flr
  // --------------------
  cl_rst_flr u_rst_flr (
    .clk_main_a0  (clk_main_a0),
    .sync_rst_n   (sync_rst_n),
    .flr_assert_i (flr_assert_i),
    .blk_rst_n_o  (blk_rst_n),
    .flr_done_o   (flr_done_o)
  );

  // --------------------
  // ocl slave and windows
  // --------------------
  cl_ocl_slave u_ocl_slave (
    .clk_main_a0   (clk_main_a0),
    .blk_rst_n_i   (blk_rst_n),
    .ocl_awvalid_i (ocl_awvalid_i),
    .ocl_awaddr_i  (ocl_awaddr_i),
    .ocl_awready_o (ocl_awready_o),
    .ocl_wvalid_i  (ocl_wvalid_i),
    .ocl_wdata_i   (ocl_wdata_i),
    .ocl_wstrb_i   (ocl_wstrb_i),
    .ocl_wready_o  (ocl_wready_o),
    .ocl_bvalid_o  (ocl_bvalid_o),
    .ocl_bresp_o   (ocl_bresp_o),
    .ocl_bready_i  (ocl_bready_i),
    .ocl_arvalid_i (ocl_arvalid_i),
    .ocl_araddr_i  (ocl_araddr_i),
    .ocl_arready_o (ocl_arready_o),
    .ocl_rvalid_o  (ocl_rvalid_o),
    .ocl_rdata_o   (ocl_rdata_o),
    .ocl_rresp_o   (ocl_rresp_o),
    .ocl_rready_i  (ocl_rready_i),
    .reg_idx_o     (reg_idx),
    .reg_wdata_o   (reg_wdata),
    .reg_wstrb_o   (reg_wstrb),
    .id_wr_o       (id_wr),
    .id_rd_o       (id_rd),
    .lb_wr_o       (lb_wr),
    .lb_rd_o       (lb_rd),
    .id_rdata_i    (id_rdata),
    .lb_rdata_i    (lb_rdata),
    .lb_err_i      (lb_err)
  );

  // window 0
  cl_id_regs u_id_regs (
    .clk_main_a0 (clk_main_a0),
    .blk_rst_n_i (blk_rst_n),
    .reg_idx_i   (reg_idx),
    .reg_wdata_i (reg_wdata),
    .reg_wstrb_i (reg_wstrb),
    .wr_i        (id_wr),
    .rd_i        (id_rd),
    .rdata_o     (id_rdata)
  );

  // window 1
  cl_loopback_fifo u_loopback_fifo (
    .clk_main_a0 (clk_main_a0),
    .blk_rst_n_i (blk_rst_n),
    .reg_idx_i   (reg_idx),
    .reg_wdata_i (reg_wdata),
    .wr_i        (lb_wr),
    .rd_i        (lb_rd),
    .rdata_o     (lb_rdata),
    .err_o       (lb_err)
  );

endmodule

/* cl_loopback_fifo.sv */
// window 1 loopback queue, words written at index 0 come back in order on later reads
`timescale 1ns/10ps
`include "cl_fsb_defs.svh"

module cl_loopback_fifo (
  input  logic                  clk_main_a0,
  input  logic                  blk_rst_n_i,
  input  cl_fsb_pkg::reg_idx_t  reg_idx_i,
  input  cl_fsb_pkg::ocl_data_t reg_wdata_i,
  input  logic                  wr_i,
  input  logic                  rd_i,
  output cl_fsb_pkg::ocl_data_t rdata_o,
  output logic                  err_o
);

  import cl_fsb_pkg::*;

  ocl_data_t                        mem [`CL_LB_DEPTH];
  logic [$clog2(`CL_LB_DEPTH)-1:0]  wr_ptr_q;
  logic [$clog2(`CL_LB_DEPTH)-1:0]  rd_ptr_q;
  lb_count_t                        count_q;
  logic                             is_data;
  logic                             is_count;
  logic                             full;
  logic                             empty;
  logic                             push;
  logic                             pop;

  // --------------------
  // access decode
  // --------------------
  assign is_data  = (reg_idx_i == 10'd0);
  assign is_count = (reg_idx_i == 10'd1);
  assign full     = (count_q == lb_count_t'(`CL_LB_DEPTH));
  assign empty    = (count_q == '0);

  assign push = wr_i && is_data && !full;
  assign pop  = rd_i && is_data && !empty;

  // overflow or underflow at the data index
  assign err_o = is_data && ((wr_i && full) || (rd_i && empty));

  // --------------------
  // storage
  // --------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (push)
      mem[wr_ptr_q] <= reg_wdata_i;
  end

  // pointers wrap at the queue depth
  always_ff @(posedge clk_main_a0)
  begin
    if (!blk_rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
      begin
        if (wr_ptr_q == ($clog2(`CL_LB_DEPTH))'(`CL_LB_DEPTH - 1))
          wr_ptr_q <= '0;
        else
          wr_ptr_q <= wr_ptr_q + 1'b1;
        count_q <= count_q + 1'b1;
      end
      else if (pop)
      begin
        if (rd_ptr_q == ($clog2(`CL_LB_DEPTH))'(`CL_LB_DEPTH - 1))
          rd_ptr_q <= '0;
        else
          rd_ptr_q <= rd_ptr_q + 1'b1;
        count_q <= count_q - 1'b1;
      end
    end
  end

  // --------------------
  // read mux
  // --------------------
  // head word on a pop, zero when empty
  always_comb
  begin
    rdata_o = '0;
    if (pop)
      rdata_o = mem[rd_ptr_q];
    else if (rd_i && is_count)
      rdata_o = ocl_data_t'(count_q);
  end

  a_lb_count_max: assert property (@(posedge clk_main_a0) disable iff (!blk_rst_n_i)
    count_q <= lb_count_t'(`CL_LB_DEPTH));

endmodule

/* cl_id_regs.sv */
// window 0 register block with the identification words and a byte-writable scratch word
`timescale 1ns/10ps
`include "cl_fsb_defs.svh"

module cl_id_regs (
  input  logic                  clk_main_a0,
  input  logic                  blk_rst_n_i,
  input  cl_fsb_pkg::reg_idx_t  reg_idx_i,
  input  cl_fsb_pkg::ocl_data_t reg_wdata_i,
  input  cl_fsb_pkg::ocl_strb_t reg_wstrb_i,
  input  logic                  wr_i,
  input  logic                  rd_i,
  output cl_fsb_pkg::ocl_data_t rdata_o
);

  import cl_fsb_pkg::*;

  ocl_data_t scratch_q;

  // --------------------
  // scratch write
  // --------------------
  // only index 2 is writable, id words are constants
  always_ff @(posedge clk_main_a0)
  begin
    if (!blk_rst_n_i)
      scratch_q <= '0;
    else if (wr_i && (reg_idx_i == 10'd2))
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (reg_wstrb_i[b])
          scratch_q[8*b +: 8] <= reg_wdata_i[8*b +: 8];
      end
    end
  end

  // --------------------
  // read mux
  // --------------------
  always_comb
  begin
    rdata_o = '0;
    if (rd_i)
    begin
      case (reg_idx_i)
        10'd0:   rdata_o = `CL_SH_ID0;
        10'd1:   rdata_o = `CL_SH_ID1;
        10'd2:   rdata_o = scratch_q;
        default: rdata_o = '0;
      endcase
    end
  end

endmodule

/* cl_ocl_slave.sv */
// ocl axi-lite slave, decodes the address window and drives the per-window access strobes
`timescale 1ns/10ps
`include "cl_fsb_defs.svh"

module cl_ocl_slave (
  input  logic                  clk_main_a0,
  input  logic                  blk_rst_n_i,
  // write address
  input  logic                  ocl_awvalid_i,
  input  cl_fsb_pkg::ocl_addr_t ocl_awaddr_i,
  output logic                  ocl_awready_o,
  // write data
  input  logic                  ocl_wvalid_i,
  input  cl_fsb_pkg::ocl_data_t ocl_wdata_i,
  input  cl_fsb_pkg::ocl_strb_t ocl_wstrb_i,
  output logic                  ocl_wready_o,
  // write response
  output logic                  ocl_bvalid_o,
  output cl_fsb_pkg::ocl_resp_t ocl_bresp_o,
  input  logic                  ocl_bready_i,
  // read address
  input  logic                  ocl_arvalid_i,
  input  cl_fsb_pkg::ocl_addr_t ocl_araddr_i,
  output logic                  ocl_arready_o,
  // read data
  output logic                  ocl_rvalid_o,
  output cl_fsb_pkg::ocl_data_t ocl_rdata_o,
  output cl_fsb_pkg::ocl_resp_t ocl_rresp_o,
  input  logic                  ocl_rready_i,
  // window access
  output cl_fsb_pkg::reg_idx_t  reg_idx_o,
  output cl_fsb_pkg::ocl_data_t reg_wdata_o,
  output cl_fsb_pkg::ocl_strb_t reg_wstrb_o,
  output logic                  id_wr_o,
  output logic                  id_rd_o,
  output logic                  lb_wr_o,
  output logic                  lb_rd_o,
  input  cl_fsb_pkg::ocl_data_t id_rdata_i,
  input  cl_fsb_pkg::ocl_data_t lb_rdata_i,
  input  logic                  lb_err_i
);

  import cl_fsb_pkg::*;

  ocl_state_e state_q;
  ocl_win_t   win;
  logic       wr_acc;
  logic       rd_acc;
  ocl_data_t  sel_rdata;
  ocl_resp_t  sel_resp;
  ocl_data_t  rdata_q;
  ocl_resp_t  resp_q;

  // --------------------
  // accept and decode
  // --------------------
  // write wins when both channels are pending
  assign wr_acc = (state_q == OCL_IDLE) && ocl_awvalid_i && ocl_wvalid_i;
  assign rd_acc = (state_q == OCL_IDLE) && ocl_arvalid_i && !wr_acc;

  assign ocl_awready_o = wr_acc;
  assign ocl_wready_o  = wr_acc;
  assign ocl_arready_o = rd_acc;

  assign win         = wr_acc ? ocl_awaddr_i[13:12] : ocl_araddr_i[13:12];
  assign reg_idx_o   = wr_acc ? ocl_awaddr_i[11:2] : ocl_araddr_i[11:2];
  assign reg_wdata_o = ocl_wdata_i;
  assign reg_wstrb_o = ocl_wstrb_i;

  // strobes only for the two live windows
  assign id_wr_o = wr_acc && (win == `CL_WIN_ID);
  assign lb_wr_o = wr_acc && (win == `CL_WIN_LB);
  assign id_rd_o = rd_acc && (win == `CL_WIN_ID);
  assign lb_rd_o = rd_acc && (win == `CL_WIN_LB);

  // response mux, dma and stream windows answer slverr
  always_comb
  begin
    sel_rdata = '0;
    sel_resp  = `CL_RESP_SLVERR;
    case (win)
      `CL_WIN_ID:
      begin
        sel_rdata = id_rdata_i;
        sel_resp  = `CL_RESP_OKAY;
      end
      `CL_WIN_LB:
      begin
        sel_rdata = lb_rdata_i;
        sel_resp  = lb_err_i ? `CL_RESP_SLVERR : `CL_RESP_OKAY;
      end
      default:
      begin
        sel_rdata = '0;
        sel_resp  = `CL_RESP_SLVERR;
      end
    endcase
  end

  // --------------------
  // fsm
  // --------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!blk_rst_n_i)
      state_q <= OCL_IDLE;
    else
    begin
      case (state_q)
        OCL_IDLE:
        begin
          if (wr_acc)
            state_q <= OCL_WRESP;
          else if (rd_acc)
            state_q <= OCL_RDATA;
        end
        OCL_WRESP:
        begin
          if (ocl_bready_i)
            state_q <= OCL_IDLE;
        end
        OCL_RDATA:
        begin
          if (ocl_rready_i)
            state_q <= OCL_IDLE;
        end
        default:
          state_q <= OCL_IDLE;
      endcase
    end
  end

  // response payload, captured on the accept edge
  always_ff @(posedge clk_main_a0)
  begin
    if (wr_acc || rd_acc)
      resp_q <= sel_resp;
    if (rd_acc)
      rdata_q <= sel_rdata;
  end

  assign ocl_bvalid_o = (state_q == OCL_WRESP);
  assign ocl_rvalid_o = (state_q == OCL_RDATA);
  assign ocl_bresp_o  = resp_q;
  assign ocl_rresp_o  = resp_q;
  assign ocl_rdata_o  = rdata_q;

  // one outstanding transaction at a time
  a_one_resp: assert property (@(posedge clk_main_a0) disable iff (!blk_rst_n_i)
    !(ocl_bvalid_o && ocl_rvalid_o));

  // held responses keep their payload under back-pressure
  a_b_stable: assert property (@(posedge clk_main_a0) disable iff (!blk_rst_n_i)
    (ocl_bvalid_o && !ocl_bready_i) |=> (ocl_bvalid_o && $stable(ocl_bresp_o)));

  a_r_stable: assert property (@(posedge clk_main_a0) disable iff (!blk_rst_n_i)
    (ocl_rvalid_o && !ocl_rready_i)
      |=> (ocl_rvalid_o && $stable(ocl_rdata_o) && $stable(ocl_rresp_o)));

endmodule

/* cl_rst_flr.sv */
// staged block reset release and function-level-reset acknowledge for the shell top
`timescale 1ns/10ps
`include "cl_fsb_defs.svh"

module cl_rst_flr (
  input  logic clk_main_a0,
  input  logic sync_rst_n,
  input  logic flr_assert_i,
  output logic blk_rst_n_o,
  output logic flr_done_o
);

  logic [`CL_RST_PIPE_STAGES-1:0] rst_pipe_q;
  logic                           flr_assert_q;

  // --------------------
  // reset pipe
  // --------------------
  // clears at once, fills with ones after sync_rst_n goes high
  always_ff @(posedge clk_main_a0)
  begin
    if (!sync_rst_n)
      rst_pipe_q <= '0;
    else
      rst_pipe_q <= {rst_pipe_q[`CL_RST_PIPE_STAGES-2:0], 1'b1};
  end

  assign blk_rst_n_o = rst_pipe_q[`CL_RST_PIPE_STAGES-1];

  // --------------------
  // flr response
  // --------------------
  // done toggles every cycle while the assert is held
  always_ff @(posedge clk_main_a0)
  begin
    if (!sync_rst_n)
    begin
      flr_assert_q <= 1'b0;
      flr_done_o   <= 1'b0;
    end
    else
    begin
      flr_assert_q <= flr_assert_i;
      flr_done_o   <= flr_assert_q && !flr_done_o;
    end
  end

  // no done pulse once the assert has been gone for two cycles
  a_flr_done_idle: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
    (!flr_assert_q && $past(!flr_assert_q)) |-> !flr_done_o);

endmodule

/* cl_fsb_pkg.sv */
// types shared by the cl_fsb register shell, import into modules that use them
package cl_fsb_pkg;

  // --------------------
  // ocl bus fields
  // --------------------
  // byte address, one word
  typedef logic [31:0] ocl_addr_t;
  typedef logic [31:0] ocl_data_t;
  typedef logic [3:0]  ocl_strb_t;
  typedef logic [1:0]  ocl_resp_t;

  // address bits 13:12
  typedef logic [1:0]  ocl_win_t;

  // word index inside a window, address bits 11:2
  typedef logic [9:0]  reg_idx_t;

  // loopback occupancy, 0 up to the full depth
  typedef logic [3:0]  lb_count_t;

  // --------------------
  // slave fsm
  // --------------------
  typedef enum logic [1:0] {
    OCL_IDLE,
    OCL_WRESP,
    OCL_RDATA
  } ocl_state_e;

endpackage

/* cl_fsb_defs.svh */
// shared constants for the cl_fsb register shell, include in any file that needs them
`ifndef CL_FSB_DEFS_SVH
`define CL_FSB_DEFS_SVH

// --------------------
// identification words
// --------------------
// read back from window 0 offsets 0x000 and 0x004
`define CL_SH_ID0 32'hC0DE_0F5B
`define CL_SH_ID1 32'h0001_0100

// --------------------
// reset and queue sizing
// --------------------
// register stages between sync_rst_n and the block reset
`define CL_RST_PIPE_STAGES 4

// loopback queue depth in 32-bit words
`define CL_LB_DEPTH 8

// --------------------
// address windows
// --------------------
// window number is address bits 13:12
`define CL_WIN_ID 2'd0
`define CL_WIN_LB 2'd1

// axi-lite response codes
`define CL_RESP_OKAY   2'b00
`define CL_RESP_SLVERR 2'b10

`endif
